/* noc_pkg.sv */
package noc_pkg;

  localparam int mesh_size_x = 3;
  localparam int mesh_size_y = 3;

  // wide enough for the larger of the two mesh dimensions.
  localparam int coord_width =
    $clog2((mesh_size_x > mesh_size_y) ? mesh_size_x : mesh_size_y);

  localparam int payload_width = 32;

  localparam int fifo_depth = 4;
  localparam int fifo_ptr_width = $clog2(fifo_depth);
  localparam int fifo_count_width = $clog2(fifo_depth + 1);
  localparam logic [fifo_ptr_width-1:0] fifo_last_ptr = fifo_ptr_width'(fifo_depth - 1);
  localparam logic [fifo_count_width-1:0] fifo_full_count = fifo_count_width'(fifo_depth);

  localparam int num_ports = 5;
  localparam int port_index_width = $clog2(num_ports);

  typedef enum logic [port_index_width-1:0] {
    port_x_plus  = 3'd0,
    port_x_minus = 3'd1,
    port_y_plus  = 3'd2,
    port_y_minus = 3'd3,
    port_local   = 3'd4
  } port_e;

  typedef enum logic [0:0] {
    routing_x_y = 1'b0,
    routing_y_x = 1'b1
  } routing_mode_e;

  typedef enum logic [1:0] {
    flit_head   = 2'd0,
    flit_body   = 2'd1,
    flit_tail   = 2'd2,
    flit_single = 2'd3
  } flit_kind_e;

  // body and tail flits repeat the header fields, only the head's copy is routed on.
  typedef struct packed {
    flit_kind_e                 kind;
    logic [coord_width-1:0]     dest_x;
    logic [coord_width-1:0]     dest_y;
    routing_mode_e              mode;
    logic [payload_width-1:0]   payload;
  } flit_t;

  // one bit per port, indexed by port_e.
  typedef logic [num_ports-1:0] port_mask_t;

  function automatic logic is_head(flit_kind_e kind);
    return (kind == flit_head) || (kind == flit_single);
  endfunction

  function automatic logic is_tail(flit_kind_e kind);
    return (kind == flit_tail) || (kind == flit_single);
  endfunction

endpackage

/* flit_fifo.sv */
`timescale 1ns/1ps

module flit_fifo (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            in_valid,
  input  noc_pkg::flit_t  in_flit,
  input  logic            pop,
  output logic            in_ready,
  output logic            head_valid,
  output noc_pkg::flit_t  head_flit
);

  noc_pkg::flit_t                         mem [noc_pkg::fifo_depth];
  logic [noc_pkg::fifo_ptr_width-1:0]     wr_ptr;
  logic [noc_pkg::fifo_ptr_width-1:0]     rd_ptr;
  logic [noc_pkg::fifo_count_width-1:0]   count;
  logic                                   push;
  logic                                   drain;

  // a full buffer still takes a flit when the head leaves in the same cycle.
  assign in_ready   = (count != noc_pkg::fifo_full_count) || pop;
  assign head_valid = (count != '0);
  assign head_flit  = mem[rd_ptr];

  assign push  = in_valid && in_ready;
  assign drain = pop && head_valid;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_flit;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == noc_pkg::fifo_last_ptr) ? '0 : wr_ptr + 1'b1;
      end
      if (drain) begin
        rd_ptr <= (rd_ptr == noc_pkg::fifo_last_ptr) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, drain})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

/* route_selector.sv */
`timescale 1ns/1ps

module route_selector #(
  parameter int x = 0,
  parameter int y = 0
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 head_valid,
  input  noc_pkg::flit_t       head_flit,
  input  logic                 grant_seen,
  input  logic                 accepted,
  output noc_pkg::port_mask_t  request
);

  noc_pkg::port_mask_t  route_next;
  noc_pkg::port_mask_t  route_latched;
  noc_pkg::port_mask_t  route;
  logic                 route_open;

  // dir holds x plus, x minus, y plus and y minus in bits 0 to 3.
  function automatic noc_pkg::port_e order_x_y(logic [3:0] dir);
    if (dir[0]) return noc_pkg::port_x_plus;
    if (dir[1]) return noc_pkg::port_x_minus;
    if (dir[2]) return noc_pkg::port_y_plus;
    if (dir[3]) return noc_pkg::port_y_minus;
    return noc_pkg::port_local;
  endfunction

  function automatic noc_pkg::port_e order_y_x(logic [3:0] dir);
    if (dir[2]) return noc_pkg::port_y_plus;
    if (dir[3]) return noc_pkg::port_y_minus;
    if (dir[0]) return noc_pkg::port_x_plus;
    if (dir[1]) return noc_pkg::port_x_minus;
    return noc_pkg::port_local;
  endfunction

  function automatic noc_pkg::port_mask_t select_route(noc_pkg::flit_t flit);
    logic [3:0]           dir;
    noc_pkg::port_e       port;
    noc_pkg::port_mask_t  mask;
    dir[0] = int'(flit.dest_x) > x;
    dir[1] = int'(flit.dest_x) < x;
    dir[2] = int'(flit.dest_y) > y;
    dir[3] = int'(flit.dest_y) < y;
    if (flit.mode == noc_pkg::routing_x_y) begin
      port = order_x_y(dir);
    end else begin
      port = order_y_x(dir);
    end
    mask       = '0;
    mask[port] = 1'b1;
    return mask;
  endfunction

  assign route_next = select_route(head_flit);
  assign route      = route_open ? route_latched : route_next;
  assign request    = head_valid ? route : '0;

  // the route is frozen from the cycle the output grants the head.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      route_open    <= 1'b0;
      route_latched <= '0;
    end else if (accepted && noc_pkg::is_tail(head_flit.kind)) begin
      route_open <= 1'b0;
    end else if (grant_seen && !route_open && noc_pkg::is_head(head_flit.kind)) begin
      route_open    <= 1'b1;
      route_latched <= route_next;
    end
  end

endmodule

/* round_robin_arbiter.sv */
`timescale 1ns/1ps

module round_robin_arbiter (
  input  logic                 clk,
  input  logic                 rst_n,
  input  noc_pkg::port_mask_t  request,
  input  logic                 end_of_packet,
  input  logic                 advance,
  output noc_pkg::port_mask_t  grant
);

  typedef enum logic {
    arb_idle,
    arb_locked
  } arb_state_e;

  arb_state_e                             state;
  logic [noc_pkg::port_index_width-1:0]   ptr;
  logic [noc_pkg::port_index_width-1:0]   held_idx;
  logic [noc_pkg::port_index_width-1:0]   win_idx;
  logic                                   found;
  logic                                   release_now;

  // search starts one past the last winner.
  always_comb begin
    int idx;
    found   = 1'b0;
    win_idx = ptr;
    for (int k = 1; k <= noc_pkg::num_ports; k++) begin
      idx = (int'(ptr) + k) % noc_pkg::num_ports;
      if (!found && request[idx]) begin
        found   = 1'b1;
        win_idx = idx[noc_pkg::port_index_width-1:0];
      end
    end
  end

  always_comb begin
    grant = '0;
    if (state == arb_locked) begin
      grant[held_idx] = 1'b1;
    end else if (found) begin
      grant[win_idx] = 1'b1;
    end
  end

  assign release_now = advance && end_of_packet;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= arb_idle;
      ptr      <= '0;
      held_idx <= '0;
    end else if (state == arb_idle) begin
      if (found && release_now) begin
        ptr <= win_idx; // single flit passes without locking.
      end else if (found) begin
        state    <= arb_locked;
        held_idx <= win_idx;
      end
    end else if (release_now) begin
      state <= arb_idle;
      ptr   <= held_idx;
    end
  end

endmodule

/* output_port.sv */
`timescale 1ns/1ps

module output_port (
  input  logic                 clk,
  input  logic                 rst_n,
  input  noc_pkg::port_mask_t  request,
  input  noc_pkg::flit_t       flits [noc_pkg::num_ports],
  input  logic                 out_ready,
  output noc_pkg::port_mask_t  grant,
  output logic                 take,
  output logic                 out_valid,
  output noc_pkg::flit_t       out_flit
);

  noc_pkg::flit_t  sel_flit;
  logic            sel_valid;
  logic            reg_free;
  logic            sel_tail;

  round_robin_arbiter u_arbiter (
    .clk           (clk),
    .rst_n         (rst_n),
    .request       (request),
    .end_of_packet (sel_tail),
    .advance       (take),
    .grant         (grant)
  );

  // grant is one-hot or empty, so at most one flit passes.
  always_comb begin
    sel_flit = '0;
    for (int i = 0; i < noc_pkg::num_ports; i++) begin
      if (grant[i]) begin
        sel_flit = flits[i];
      end
    end
  end

  // the granted input may have a gap between flits of its packet.
  assign sel_valid = |(grant & request);
  assign sel_tail  = noc_pkg::is_tail(sel_flit.kind);

  assign reg_free = !out_valid || out_ready;
  assign take     = sel_valid && reg_free;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (reg_free) begin
      out_valid <= sel_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      out_flit <= sel_flit;
    end
  end

endmodule

/* noc_router.sv */
`timescale 1ns/1ps

module noc_router #(
  parameter int x = 0,
  parameter int y = 0
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            in_valid  [noc_pkg::num_ports],
  input  noc_pkg::flit_t  in_flit   [noc_pkg::num_ports],
  output logic            in_ready  [noc_pkg::num_ports],
  output logic            out_valid [noc_pkg::num_ports],
  output noc_pkg::flit_t  out_flit  [noc_pkg::num_ports],
  input  logic            out_ready [noc_pkg::num_ports]
);

  logic                 head_valid   [noc_pkg::num_ports];
  noc_pkg::flit_t       head_flit    [noc_pkg::num_ports];
  logic                 pop          [noc_pkg::num_ports];
  logic                 grant_seen   [noc_pkg::num_ports];
  noc_pkg::port_mask_t  request      [noc_pkg::num_ports]; // per input, bit per output.
  noc_pkg::port_mask_t  port_request [noc_pkg::num_ports]; // per output, bit per input.
  noc_pkg::port_mask_t  grant        [noc_pkg::num_ports]; // per output, bit per input.
  noc_pkg::port_mask_t  input_grant  [noc_pkg::num_ports]; // per input, bit per output.
  noc_pkg::port_mask_t  take_mask;

  for (genvar i = 0; i < noc_pkg::num_ports; i++) begin : g_transpose
    for (genvar j = 0; j < noc_pkg::num_ports; j++) begin : g_bit
      assign port_request[j][i] = request[i][j];
      assign input_grant[i][j]  = grant[j][i];
    end
  end

  for (genvar i = 0; i < noc_pkg::num_ports; i++) begin : g_input
    // request is one-hot, so only the routed output can pop this input.
    assign grant_seen[i] = |(request[i] & input_grant[i]);
    assign pop[i]        = |(request[i] & input_grant[i] & take_mask);

    flit_fifo u_fifo (
      .clk        (clk),
      .rst_n      (rst_n),
      .in_valid   (in_valid[i]),
      .in_flit    (in_flit[i]),
      .pop        (pop[i]),
      .in_ready   (in_ready[i]),
      .head_valid (head_valid[i]),
      .head_flit  (head_flit[i])
    );

    route_selector #(
      .x (x),
      .y (y)
    ) u_route (
      .clk        (clk),
      .rst_n      (rst_n),
      .head_valid (head_valid[i]),
      .head_flit  (head_flit[i]),
      .grant_seen (grant_seen[i]),
      .accepted   (pop[i]),
      .request    (request[i])
    );
  end

  for (genvar j = 0; j < noc_pkg::num_ports; j++) begin : g_output
    output_port u_output (
      .clk       (clk),
      .rst_n     (rst_n),
      .request   (port_request[j]),
      .flits     (head_flit),
      .out_ready (out_ready[j]),
      .grant     (grant[j]),
      .take      (take_mask[j]),
      .out_valid (out_valid[j]),
      .out_flit  (out_flit[j])
    );
  end

endmodule

/* tb_noc_router.sv */
`timescale 1ns/1ps

module tb_noc_router;

  typedef struct packed {
    logic [3:0]             slot;
    noc_pkg::port_e         src;
    logic [1:0]             dx;
    logic [1:0]             dy;
    noc_pkg::routing_mode_e mode;
    logic [2:0]             len;
    logic [31:0]            base;
  } packet_t;

  localparam int num_packets = 28;
  localparam int num_slots = 8;
  localparam int random_from_slot = 6; // out_ready turns random from this slot on.

  localparam packet_t packets [num_packets] = '{
    '{4'd0, noc_pkg::port_local,   2'd2, 2'd2, noc_pkg::routing_x_y, 3'd2, 32'h1000},
    '{4'd0, noc_pkg::port_x_plus,  2'd0, 2'd0, noc_pkg::routing_x_y, 3'd3, 32'h1100},
    '{4'd1, noc_pkg::port_y_plus,  2'd2, 2'd0, noc_pkg::routing_x_y, 3'd1, 32'h1200},
    '{4'd1, noc_pkg::port_y_minus, 2'd0, 2'd2, noc_pkg::routing_x_y, 3'd4, 32'h1300},
    '{4'd1, noc_pkg::port_local,   2'd1, 2'd2, noc_pkg::routing_x_y, 3'd2, 32'h1400},
    '{4'd1, noc_pkg::port_x_minus, 2'd1, 2'd0, noc_pkg::routing_x_y, 3'd2, 32'h1500},
    '{4'd2, noc_pkg::port_local,   2'd2, 2'd1, noc_pkg::routing_y_x, 3'd2, 32'h1600},
    '{4'd2, noc_pkg::port_y_plus,  2'd0, 2'd1, noc_pkg::routing_x_y, 3'd1, 32'h1700},
    '{4'd3, noc_pkg::port_local,   2'd2, 2'd2, noc_pkg::routing_y_x, 3'd3, 32'h1800},
    '{4'd3, noc_pkg::port_x_plus,  2'd0, 2'd0, noc_pkg::routing_y_x, 3'd2, 32'h1900},
    '{4'd3, noc_pkg::port_x_minus, 2'd2, 2'd0, noc_pkg::routing_y_x, 3'd1, 32'h1a00},
    '{4'd3, noc_pkg::port_y_minus, 2'd0, 2'd2, noc_pkg::routing_y_x, 3'd2, 32'h1b00},
    '{4'd4, noc_pkg::port_x_plus,  2'd1, 2'd1, noc_pkg::routing_x_y, 3'd1, 32'h1c00},
    '{4'd4, noc_pkg::port_y_plus,  2'd1, 2'd1, noc_pkg::routing_y_x, 3'd3, 32'h1d00},
    '{4'd5, noc_pkg::port_local,   2'd2, 2'd1, noc_pkg::routing_x_y, 3'd4, 32'h2000},
    '{4'd5, noc_pkg::port_x_minus, 2'd2, 2'd0, noc_pkg::routing_x_y, 3'd4, 32'h2100},
    '{4'd5, noc_pkg::port_y_plus,  2'd2, 2'd2, noc_pkg::routing_x_y, 3'd3, 32'h2200},
    '{4'd5, noc_pkg::port_y_minus, 2'd2, 2'd1, noc_pkg::routing_y_x, 3'd4, 32'h2300},
    '{4'd5, noc_pkg::port_x_plus,  2'd2, 2'd2, noc_pkg::routing_x_y, 3'd2, 32'h2400},
    '{4'd6, noc_pkg::port_local,   2'd0, 2'd2, noc_pkg::routing_y_x, 3'd4, 32'h3000},
    '{4'd6, noc_pkg::port_x_plus,  2'd1, 2'd2, noc_pkg::routing_x_y, 3'd3, 32'h3100},
    '{4'd6, noc_pkg::port_x_minus, 2'd2, 2'd2, noc_pkg::routing_x_y, 3'd4, 32'h3200},
    '{4'd6, noc_pkg::port_y_plus,  2'd1, 2'd1, noc_pkg::routing_x_y, 3'd2, 32'h3300},
    '{4'd6, noc_pkg::port_y_minus, 2'd0, 2'd0, noc_pkg::routing_x_y, 3'd4, 32'h3400},
    '{4'd7, noc_pkg::port_local,   2'd2, 2'd0, noc_pkg::routing_y_x, 3'd3, 32'h3500},
    '{4'd7, noc_pkg::port_y_minus, 2'd2, 2'd0, noc_pkg::routing_y_x, 3'd4, 32'h3600},
    '{4'd7, noc_pkg::port_x_minus, 2'd1, 2'd1, noc_pkg::routing_y_x, 3'd1, 32'h3700},
    '{4'd7, noc_pkg::port_y_plus,  2'd0, 2'd1, noc_pkg::routing_x_y, 3'd4, 32'h3800}
  };

  logic            clk;
  logic            rst_n;
  logic            in_valid  [noc_pkg::num_ports];
  noc_pkg::flit_t  in_flit   [noc_pkg::num_ports];
  logic            in_ready  [noc_pkg::num_ports];
  logic            out_valid [noc_pkg::num_ports];
  noc_pkg::flit_t  out_flit  [noc_pkg::num_ports];
  logic            out_ready [noc_pkg::num_ports];

  int  seed = 46859;
  bit  random_ready;
  int  expect_q [noc_pkg::num_ports][$]; // packet indices still owed per output.
  int  open_entry [noc_pkg::num_ports];
  int  flit_idx [noc_pkg::num_ports];
  int  received;

  noc_router #(
    .x (1),
    .y (1)
  ) DUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_flit   (in_flit),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_flit  (out_flit),
    .out_ready (out_ready)
  );

  always #20 clk = ~clk;

  // router sits at (1,1); the mode picks which axis is corrected first.
  function automatic noc_pkg::port_e expected_port(int dx, int dy, noc_pkg::routing_mode_e mode);
    if (dx == 1 && dy == 1) return noc_pkg::port_local;
    if (mode == noc_pkg::routing_x_y && dx != 1) begin
      return (dx > 1) ? noc_pkg::port_x_plus : noc_pkg::port_x_minus;
    end
    if (mode == noc_pkg::routing_y_x && dy == 1) begin
      return (dx > 1) ? noc_pkg::port_x_plus : noc_pkg::port_x_minus;
    end
    return (dy > 1) ? noc_pkg::port_y_plus : noc_pkg::port_y_minus;
  endfunction

  function automatic noc_pkg::flit_kind_e expected_kind(int e, int k);
    if (packets[e].len == 3'd1) return noc_pkg::flit_single;
    if (k == 0) return noc_pkg::flit_head;
    if (k == int'(packets[e].len) - 1) return noc_pkg::flit_tail;
    return noc_pkg::flit_body;
  endfunction

  function automatic noc_pkg::flit_t make_flit(int e, int k);
    noc_pkg::flit_t flit;
    flit.kind    = expected_kind(e, k);
    flit.dest_x  = packets[e].dx;
    flit.dest_y  = packets[e].dy;
    flit.mode    = packets[e].mode;
    flit.payload = packets[e].base + 32'(k);
    return flit;
  endfunction

  function automatic int total_flits();
    int n = 0;
    for (int e = 0; e < num_packets; e++) begin
      n += int'(packets[e].len);
    end
    return n;
  endfunction

  task automatic check_value(string name, int actual, int expected);
    assert (actual == expected) else begin
      $display("** Error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, actual, expected);
      $display("Test FAILED");
      $fatal(1, "stopping on first error");
    end
  endtask

  task automatic require(bit cond, string what);
    assert (cond) else begin
      $display("** Error at %0t ns: %s", $time, what);
      $display("Test FAILED");
      $fatal(1, "stopping on first error");
    end
  endtask

  // a head claims the first owed packet with its payload base; the rest must follow it.
  task automatic check_output(int j, noc_pkg::flit_t flit);
    int found;
    int e;
    int k;
    found = -1;
    if (open_entry[j] < 0) begin
      for (int q = 0; q < expect_q[j].size(); q++) begin
        if (found < 0 && packets[expect_q[j][q]].base == flit.payload) found = q;
      end
      require(found >= 0, $sformatf("port %0d sent payload 0x%0h that starts no owed packet",
                                    j, flit.payload));
      open_entry[j] = expect_q[j][found];
      expect_q[j].delete(found);
      flit_idx[j] = 0;
    end
    e = open_entry[j];
    k = flit_idx[j];
    check_value($sformatf("out_flit[%0d].payload", j), int'(flit.payload),
                int'(packets[e].base) + k);
    check_value($sformatf("out_flit[%0d].kind", j), int'(flit.kind), int'(expected_kind(e, k)));
    check_value($sformatf("out_flit[%0d].dest_x", j), int'(flit.dest_x), int'(packets[e].dx));
    check_value($sformatf("out_flit[%0d].dest_y", j), int'(flit.dest_y), int'(packets[e].dy));
    check_value($sformatf("out_flit[%0d].mode", j), int'(flit.mode), int'(packets[e].mode));
    received++;
    flit_idx[j] = k + 1;
    if (k == int'(packets[e].len) - 1) open_entry[j] = -1;
  endtask

  task automatic send_packet(int e);
    int p;
    p = int'(packets[e].src);
    for (int k = 0; k < int'(packets[e].len); k++) begin
      @(posedge clk);
      in_valid[p] <= 1'b1;
      in_flit[p]  <= make_flit(e, k);
      do @(negedge clk); while (!in_ready[p]); // the flit moves on the next rising edge.
    end
    @(posedge clk);
    in_valid[p] <= 1'b0;
  endtask

  task automatic drive_port_slot(noc_pkg::port_e src, int slot);
    for (int e = 0; e < num_packets; e++) begin
      if (packets[e].src == src && int'(packets[e].slot) == slot) send_packet(e);
    end
  endtask

  always @(posedge clk) begin
    int r;
    for (int j = 0; j < noc_pkg::num_ports; j++) begin
      r = $random(seed);
      out_ready[j] <= random_ready ? (r[1:0] != 2'b00) : 1'b1;
    end
  end

  // handshake values are settled at the falling edge.
  always @(negedge clk) begin
    if (rst_n) begin
      for (int j = 0; j < noc_pkg::num_ports; j++) begin
        if (out_valid[j] && out_ready[j]) check_output(j, out_flit[j]);
      end
    end
  end

  initial begin
    int limit;
    limit = 16 + 200 * total_flits();
    repeat (limit) @(posedge clk);
    $display("Timeout: the router did not deliver every packet within %0d cycles", limit);
    $display("Test FAILED");
    $fatal(1, "watchdog expired");
  end

  initial begin
    bit drained;
    clk          = 1'b0;
    rst_n        = 1'b0;
    random_ready = 1'b0;
    received     = 0;
    for (int j = 0; j < noc_pkg::num_ports; j++) begin
      in_valid[j]   = 1'b0;
      in_flit[j]    = '0;
      out_ready[j]  = 1'b1;
      open_entry[j] = -1;
      flit_idx[j]   = 0;
    end
    for (int e = 0; e < num_packets; e++) begin
      expect_q[int'(expected_port(int'(packets[e].dx), int'(packets[e].dy),
                                  packets[e].mode))].push_back(e);
    end
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    for (int j = 0; j < noc_pkg::num_ports; j++) begin
      check_value($sformatf("out_valid[%0d]", j), int'(out_valid[j]), 0);
      check_value($sformatf("in_ready[%0d]", j), int'(in_ready[j]), 1);
    end
    for (int s = 0; s < num_slots; s++) begin
      if (s == random_from_slot) random_ready = 1'b1;
      fork
        drive_port_slot(noc_pkg::port_x_plus, s);
        drive_port_slot(noc_pkg::port_x_minus, s);
        drive_port_slot(noc_pkg::port_y_plus, s);
        drive_port_slot(noc_pkg::port_y_minus, s);
        drive_port_slot(noc_pkg::port_local, s);
      join
    end
    while (received < total_flits()) @(negedge clk);
    repeat (10) @(negedge clk); // a duplicate would show up here.
    drained = (received == total_flits());
    for (int j = 0; j < noc_pkg::num_ports; j++) begin
      if (expect_q[j].size() != 0 || open_entry[j] >= 0 || out_valid[j]) drained = 1'b0;
    end
    if (drained) begin
      $display("Test OK");
      $finish;
    end else begin
      $display("Drain check: packets or flits were left over after the last delivery");
      $display("Test FAILED");
      $fatal(1, "router did not drain cleanly");
    end
  end

endmodule

/* verilog.f */
noc_pkg.sv
flit_fifo.sv
route_selector.sv
round_robin_arbiter.sv
output_port.sv
noc_router.sv
tb_noc_router.sv

/* Makefile */
# Verilator build of the router testbench.

SIM := obj_dir/Vtb_noc_router

all: $(SIM)

# rebuilt only when the file list or one of its sources changes
$(SIM): verilog.f $(shell cat verilog.f)
	verilator --binary --timing -j 0 --top-module tb_noc_router -f verilog.f

# exit status of the simulator is the pass or fail result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf obj_dir

.PHONY: all run clean
